// ==== include/board_defs.svh ====
// width constants only, meant to be included inside board_pkg, sample width must stay below gain width
`ifndef BOARD_DEFS_SVH
`define BOARD_DEFS_SVH

// sample width after the converter bus is trimmed
localparam int unsigned SAMPLE_W  = 14;
// raw converter bus, two spare bits at the bottom
localparam int unsigned ADC_BUS_W = 16;
// number of low bits dropped from the converter word
localparam int unsigned ADC_DROP  = ADC_BUS_W - SAMPLE_W;

// calibration gain, fixed point with GAIN_FRAC fraction bits
localparam int unsigned GAIN_W    = 16;
// 2**GAIN_FRAC is unity gain
localparam int unsigned GAIN_FRAC = 14;

// signed sample limits used by saturation
localparam int SMP_MAX = 2**(SAMPLE_W-1) - 1;
localparam int SMP_MIN = -(2**(SAMPLE_W-1));

`endif

// ==== source/board_pkg.sv ====
// sample, gain and calibration types for the board data path, no clocks or logic live here
package board_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  `include "board_defs.svh"

  ////////////////////////////////////////////////////////////////////////////
  // sample types
  ////////////////////////////////////////////////////////////////////////////

  // two's complement sample as seen inside the fabric
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // raw converter word, offset binary with inverted slope
  typedef logic [ADC_BUS_W-1:0] adc_bus_t;

  // code driven toward the DAC
  typedef logic [SAMPLE_W-1:0] dac_code_t;

  ////////////////////////////////////////////////////////////////////////////
  // calibration
  ////////////////////////////////////////////////////////////////////////////

  // signed fixed point gain
  typedef logic signed [GAIN_W-1:0] gain_t;

  // per channel coefficients
  // gain in the upper bits, offset below
  typedef struct packed {
    gain_t   gain;
    sample_t offset;
  } calib_t;

  ////////////////////////////////////////////////////////////////////////////
  // triggers
  ////////////////////////////////////////////////////////////////////////////

  // single cycle events from the debounced GPIO
  typedef struct packed {
    // debounced level went high
    logic rise;
    // debounced level went low
    logic fall;
  } gpio_trig_t;

endpackage : board_pkg

// ==== source/adc_capture.sv ====
// one cycle capture of the converter bus, loop select is not registered before it takes effect
`timescale 1ns/1ps

module adc_capture #(
  // number of ADC channels
  parameter int unsigned NCH = 2
)(
  input  logic                           adc_clk,
  input  logic                           top_rst,
  // raw converter words
  input  board_pkg::adc_bus_t [NCH-1:0]  adc_raw_i,
  // calibrated generator samples for digital loopback
  input  board_pkg::sample_t  [NCH-1:0]  dac_loop_i,
  // loopback select per channel
  input  logic                [NCH-1:0]  loop_i,
  // captured samples
  output board_pkg::sample_t  [NCH-1:0]  adc_smp_o
);

  import board_pkg::*;

  // converted converter word, before the loopback switch
  sample_t adc_cnv [NCH];

  ////////////////////////////////////////////////////////////////////////////
  // bus conversion
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int c = 0; c < NCH; c++) begin
      // sign bit stays, remaining bits flipped for the negative slope
      // spare low bits dropped
      adc_cnv[c] = {adc_raw_i[c][ADC_BUS_W-1], ~adc_raw_i[c][ADC_BUS_W-2:ADC_DROP]};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // loopback switch and capture register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      adc_smp_o <= '0;
    end else begin
      for (int c = 0; c < NCH; c++) begin
        // generator sample replaces the converter when looped
        adc_smp_o[c] <= loop_i[c] ? dac_loop_i[c] : adc_cnv[c];
      end
    end
  end

  // output cleared for as long as reset is held
  a_rst_zero : assert property (
    @(posedge adc_clk) top_rst |-> (adc_smp_o == '0)
  ) else $error("adc_capture output not zero during reset");

endmodule : adc_capture

// ==== source/calib_linear.sv ====
// two cycle gain and offset stage whose coefficients come live from the ports and are not pipelined
`timescale 1ns/1ps

module calib_linear #(
  // number of channels
  parameter int unsigned NCH = 2
)(
  input  logic                          adc_clk,
  input  logic                          top_rst,
  // input samples
  input  board_pkg::sample_t [NCH-1:0]  smp_i,
  // gain and offset per channel
  input  board_pkg::calib_t  [NCH-1:0]  cal_i,
  // calibrated samples
  output board_pkg::sample_t [NCH-1:0]  smp_o
);

  import board_pkg::*;

  // full product width
  localparam int unsigned MUL_W = SAMPLE_W + GAIN_W;
  // product with the fraction removed
  localparam int unsigned SCL_W = MUL_W - GAIN_FRAC;
  // one extra bit for the offset add
  localparam int unsigned SUM_W = SCL_W + 1;

  // stage one
  logic signed [MUL_W-1:0] mul   [NCH];
  logic signed [SCL_W-1:0] scl_q [NCH];
  // stage two
  logic signed [SUM_W-1:0] sum   [NCH];

  ////////////////////////////////////////////////////////////////////////////
  // stage one gain multiply
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int c = 0; c < NCH; c++) begin
      mul[c] = $signed(smp_i[c]) * $signed(cal_i[c].gain);
    end
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      for (int c = 0; c < NCH; c++) begin
        scl_q[c] <= '0;
      end
    end else begin
      for (int c = 0; c < NCH; c++) begin
        // dropping the fraction bits is an arithmetic shift
        // rounds toward minus infinity
        scl_q[c] <= mul[c][MUL_W-1:GAIN_FRAC];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage two offset add and saturation
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int c = 0; c < NCH; c++) begin
      // both operands sign extended to SUM_W
      sum[c] = scl_q[c] + $signed(cal_i[c].offset);
    end
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      smp_o <= '0;
    end else begin
      for (int c = 0; c < NCH; c++) begin
        if (sum[c] > SMP_MAX) begin
          smp_o[c] <= sample_t'(SMP_MAX);
        end else if (sum[c] < SMP_MIN) begin
          smp_o[c] <= sample_t'(SMP_MIN);
        end else begin
          // in range so the upper bits are only sign copies
          smp_o[c] <= sum[c][SAMPLE_W-1:0];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // a clamped output keeps the sign of the sum it came from
  for (genvar c = 0; c < NCH; c++) begin : g_chk
    a_no_wrap : assert property (
      @(posedge adc_clk) disable iff (top_rst)
      1'b1 |=> (smp_o[c][SAMPLE_W-1] == $past(sum[c][SUM_W-1]))
    ) else $error("calib_linear ch%0d output sign differs from the sum", c);
  end

endmodule : calib_linear

// ==== source/dac_format.sv ====
// registered signed to DAC code conversion, the DAC is assumed to have a negative slope
`timescale 1ns/1ps

module dac_format #(
  // number of DAC channels
  parameter int unsigned NCH = 2
)(
  input  logic                            adc_clk,
  input  logic                            top_rst,
  // calibrated generator samples
  input  board_pkg::sample_t   [NCH-1:0]  smp_i,
  // DAC codes, channels side by side
  output board_pkg::dac_code_t [NCH-1:0]  dac_dat_o
);

  import board_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // code conversion
  ////////////////////////////////////////////////////////////////////////////

  // offset binary with inverted slope
  // same as flipping all but the sign bit
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_dat_o <= '0;
    end else begin
      for (int c = 0; c < NCH; c++) begin
        dac_dat_o[c] <= {smp_i[c][SAMPLE_W-1], ~smp_i[c][SAMPLE_W-2:0]};
      end
    end
  end

endmodule : dac_format

// ==== source/gpio_debounce.sv ====
// GPIO debounce with edge pulses, DEB_LEN must fit in DEB_CW bits and the level starts low
`timescale 1ns/1ps

module gpio_debounce #(
  // cycles the input must stay put
  parameter int unsigned DEB_LEN = 62500,
  // counter width
  parameter int unsigned DEB_CW  = 20
)(
  input  logic                  adc_clk,
  input  logic                  top_rst,
  // asynchronous pin
  input  logic                  pin_i,
  // one cycle edge pulses
  output board_pkg::gpio_trig_t trig_o
);

  // two flop synchronizer
  logic [1:0] pin_sync;
  // synchronized pin, one cycle later
  logic       pin_d;
  // stable time counter
  logic [DEB_CW-1:0] cnt;
  // debounced level
  logic       lvl;

  // synchronized input moved this cycle
  logic       pin_chg;
  // input has been stable long enough
  logic       pin_ok;

  assign pin_chg = pin_sync[1] ^ pin_d;
  assign pin_ok  = (cnt == DEB_CW'(DEB_LEN));

  ////////////////////////////////////////////////////////////////////////////
  // synchronizer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      pin_sync <= '0;
      pin_d    <= 1'b0;
    end else begin
      pin_sync <= {pin_sync[0], pin_i};
      pin_d    <= pin_sync[1];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stability counter
  ////////////////////////////////////////////////////////////////////////////

  // restart on every change, stop counting at DEB_LEN
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      cnt <= '0;
    end else if (pin_chg) begin
      cnt <= '0;
    end else if (!pin_ok) begin
      cnt <= cnt + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // level and edge pulses
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      lvl         <= 1'b0;
      trig_o.rise <= 1'b0;
      trig_o.fall <= 1'b0;
    end else begin
      if (pin_ok) begin
        lvl <= pin_d;
      end
      // pulse in the same cycle the level flips
      trig_o.rise <= pin_ok &  pin_d & ~lvl;
      trig_o.fall <= pin_ok & ~pin_d &  lvl;
    end
  end

  // pulses are exclusive and last a single cycle
  a_trig_one : assert property (
    @(posedge adc_clk) disable iff (top_rst)
    (trig_o.rise || trig_o.fall) |->
      !(trig_o.rise && trig_o.fall) ##1 !(trig_o.rise || trig_o.fall)
  ) else $error("gpio_debounce trigger pulses overlap or stretch");

endmodule : gpio_debounce

// ==== source/board_top.sv ====
// sample path top level, every stage takes one sample per channel per adc_clk with no stalls
`timescale 1ns/1ps

module board_top #(
  // analog channels per direction
  parameter int unsigned NCH     = 2,
  // debounce length in cycles, 0.5 ms at 125 MHz
  parameter int unsigned DEB_LEN = 62500,
  // debounce counter width
  parameter int unsigned DEB_CW  = 20
)(
  input  logic                            adc_clk,
  input  logic                            top_rst,
  // converter bus
  input  board_pkg::adc_bus_t  [NCH-1:0]  adc_dat_i,
  // calibration coefficients
  input  board_pkg::calib_t    [NCH-1:0]  adc_cal_i,
  input  board_pkg::calib_t    [NCH-1:0]  dac_cal_i,
  // digital loopback select
  input  logic                 [NCH-1:0]  loop_i,
  // generator samples from outside
  input  board_pkg::sample_t   [NCH-1:0]  gen_dat_i,
  // GPIO expansion pin
  input  logic                            exp_i,
  // acquisition stream
  output board_pkg::sample_t   [NCH-1:0]  adc_dat_o,
  // DAC codes
  output board_pkg::dac_code_t [NCH-1:0]  dac_dat_o,
  // GPIO trigger events
  output board_pkg::gpio_trig_t           gpio_trig_o
);

  import board_pkg::*;

  // calibrated generator samples, shared by DAC and loopback
  sample_t [NCH-1:0] dac_smp;
  // captured ADC samples before calibration
  sample_t [NCH-1:0] adc_smp;

  ////////////////////////////////////////////////////////////////////////////
  // generation path
  ////////////////////////////////////////////////////////////////////////////

  calib_linear #(
    .NCH (NCH)
  ) dac_cal (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .smp_i   (gen_dat_i),
    .cal_i   (dac_cal_i),
    .smp_o   (dac_smp)
  );

  dac_format #(
    .NCH (NCH)
  ) dac_format_inst (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .smp_i     (dac_smp),
    .dac_dat_o (dac_dat_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // acquisition path
  ////////////////////////////////////////////////////////////////////////////

  // loopback taps the DAC samples before formatting
  adc_capture #(
    .NCH (NCH)
  ) adc_capture_inst (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .adc_raw_i  (adc_dat_i),
    .dac_loop_i (dac_smp),
    .loop_i     (loop_i),
    .adc_smp_o  (adc_smp)
  );

  calib_linear #(
    .NCH (NCH)
  ) adc_cal (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .smp_i   (adc_smp),
    .cal_i   (adc_cal_i),
    .smp_o   (adc_dat_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // GPIO trigger
  ////////////////////////////////////////////////////////////////////////////

  gpio_debounce #(
    .DEB_LEN (DEB_LEN),
    .DEB_CW  (DEB_CW)
  ) gpio_debounce_inst (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .pin_i   (exp_i),
    .trig_o  (gpio_trig_o)
  );

endmodule : board_top

// ==== verif/board_top_tb.sv ====
// run from the project root so the pattern path resolves, DEB_LEN is shortened to 16 cycles
`timescale 1ns/1ps

module board_top_tb;

  import board_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // setup
  ////////////////////////////////////////////////////////////////////////////

  localparam int NCH       = 2;
  localparam int DEB_LEN   = 16;
  localparam int DEB_CW    = 20;
  localparam int RST_CYC   = 5;
  // pattern records, 16 bit words per record
  localparam int NREC      = 22;
  localparam int REC_W     = 17;
  // word offsets inside a record
  localparam int W_FLG     = 0;
  localparam int W_ADC     = 1;
  localparam int W_ACAL    = 3;
  localparam int W_DCAL    = 7;
  localparam int W_GEN     = 11;
  localparam int W_XADC    = 13;
  localparam int W_XDAC    = 15;
  // longest wait for a trigger after a clean change
  localparam int EDGE_WAIT = 2 * DEB_LEN + 8;

  logic                adc_clk;
  logic                top_rst;
  adc_bus_t  [NCH-1:0] adc_dat_i;
  calib_t    [NCH-1:0] adc_cal_i;
  calib_t    [NCH-1:0] dac_cal_i;
  logic      [NCH-1:0] loop_i;
  sample_t   [NCH-1:0] gen_dat_i;
  logic                exp_i;
  sample_t   [NCH-1:0] adc_dat_o;
  dac_code_t [NCH-1:0] dac_dat_o;
  gpio_trig_t          gpio_trig_o;

  // flat record memory
  logic [15:0] pat [NREC*REC_W];
  integer      seed;

  board_top #(
    .NCH     (NCH),
    .DEB_LEN (DEB_LEN),
    .DEB_CW  (DEB_CW)
  ) board_top_inst (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .adc_dat_i   (adc_dat_i),
    .adc_cal_i   (adc_cal_i),
    .dac_cal_i   (dac_cal_i),
    .loop_i      (loop_i),
    .gen_dat_i   (gen_dat_i),
    .exp_i       (exp_i),
    .adc_dat_o   (adc_dat_o),
    .dac_dat_o   (dac_dat_o),
    .gpio_trig_o (gpio_trig_o)
  );

  // 10 ns clock
  initial begin
    adc_clk = 1'b0;
    forever begin
      #5 adc_clk = ~adc_clk;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // error handling and compares
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_sample(input sample_t act, input sample_t exp, input string what);
    if (act !== exp) begin
      $display("FAIL t=%0t %s got %0d expected %0d", $time, what, act, exp);
      abort_run();
    end
  endtask

  task automatic check_dac(input dac_code_t act, input dac_code_t exp, input string what);
    if (act !== exp) begin
      $display("FAIL t=%0t %s got 0x%h expected 0x%h", $time, what, act, exp);
      abort_run();
    end
  endtask

  task automatic check_trig(input gpio_trig_t act, input gpio_trig_t exp, input string what);
    if (act !== exp) begin
      $display("FAIL t=%0t %s got rise/fall %b expected %b", $time, what, act, exp);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // pattern access
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [15:0] rec_word(input int r, input int w);
    return pat[r*REC_W + w];
  endfunction

  // out of range records count as unchecked
  function automatic logic rec_checked(input int r);
    return (r >= 0) && (r < NREC) && pat[r*REC_W + W_FLG][0];
  endfunction

  function automatic logic rec_loop(input int r, input int c);
    return pat[r*REC_W + W_FLG][1 + c];
  endfunction

  task automatic apply_record(input int r);
    for (int c = 0; c < NCH; c++) begin
      adc_dat_i[c]        = rec_word(r, W_ADC + c);
      adc_cal_i[c].gain   = gain_t'(rec_word(r, W_ACAL + 2*c));
      adc_cal_i[c].offset = sample_t'(rec_word(r, W_ACAL + 2*c + 1));
      dac_cal_i[c].gain   = gain_t'(rec_word(r, W_DCAL + 2*c));
      dac_cal_i[c].offset = sample_t'(rec_word(r, W_DCAL + 2*c + 1));
      gen_dat_i[c]        = sample_t'(rec_word(r, W_GEN + c));
      loop_i[c]           = rec_loop(r, c);
    end
  endtask

  // outputs after edge k against the records that produced them
  task automatic compare_cycle(input int k);
    for (int c = 0; c < NCH; c++) begin
      // direct ADC path, three cycles
      if (rec_checked(k - 2) && !rec_loop(k - 2, c)) begin
        check_sample(adc_dat_o[c], sample_t'(rec_word(k - 2, W_XADC + c)),
                     $sformatf("adc_dat_o[%0d] rec %0d", c, k - 2));
      end
      // loopback through both calibrations, five cycles
      if (rec_checked(k - 4) && rec_loop(k - 4, c)) begin
        check_sample(adc_dat_o[c], sample_t'(rec_word(k - 4, W_XADC + c)),
                     $sformatf("looped adc_dat_o[%0d] rec %0d", c, k - 4));
      end
      if (rec_checked(k - 2)) begin
        check_dac(dac_dat_o[c], dac_code_t'(rec_word(k - 2, W_XDAC + c)),
                  $sformatf("dac_dat_o[%0d] rec %0d", c, k - 2));
      end
    end
    check_trig(gpio_trig_o, '0, "gpio_trig_o while pin idle");
  endtask

  task automatic check_idle();
    for (int c = 0; c < NCH; c++) begin
      check_sample(adc_dat_o[c], '0, "adc_dat_o in reset");
      check_dac(dac_dat_o[c], '0, "dac_dat_o in reset");
    end
    check_trig(gpio_trig_o, '0, "gpio_trig_o in reset");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // GPIO stimulus
  ////////////////////////////////////////////////////////////////////////////

  // hold the pin, no pulse allowed
  task automatic gpio_hold(input logic lvl, input int n);
    repeat (n) begin
      @(negedge adc_clk);
      check_trig(gpio_trig_o, '0, "gpio_trig_o without clean edge");
      exp_i = lvl;
    end
  endtask

  // clean change, exactly one pulse of the matching kind
  task automatic gpio_edge(input logic lvl);
    gpio_trig_t want;
    int         waited;
    want.rise = lvl;
    want.fall = ~lvl;
    waited    = 0;
    @(negedge adc_clk);
    check_trig(gpio_trig_o, '0, "gpio_trig_o before clean edge");
    exp_i = lvl;
    do begin
      @(negedge adc_clk);
      waited++;
    end while ((gpio_trig_o == '0) && (waited < EDGE_WAIT));
    if (gpio_trig_o == '0) begin
      $display("no GPIO trigger pulse within %0d cycles of a clean change", EDGE_WAIT);
      abort_run();
    end
    if (waited < DEB_LEN) begin
      $display("GPIO trigger pulse came %0d cycles after the change, too early", waited);
      abort_run();
    end
    check_trig(gpio_trig_o, want, "gpio_trig_o on clean edge");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    logic lvl;
    int   g;
    top_rst   = 1'b1;
    adc_dat_i = '0;
    adc_cal_i = '0;
    dac_cal_i = '0;
    loop_i    = '0;
    gen_dat_i = '0;
    exp_i     = 1'b0;
    seed      = 32'h65fb7b3c;
    $readmemh("verif/calib_patterns.mem", pat);
    if (^pat[NREC*REC_W-1] === 1'bx) begin
      $display("pattern file verif/calib_patterns.mem is missing or too short");
      abort_run();
    end
    repeat (RST_CYC) begin
      @(negedge adc_clk);
      check_idle();
    end
    top_rst = 1'b0;
    apply_record(0);
    // replay, then flush the five cycle loopback latency
    for (int k = 0; k < NREC + 4; k++) begin
      @(negedge adc_clk);
      compare_cycle(k);
      if (k + 1 < NREC) begin
        apply_record(k + 1);
      end
    end
    // alternate rise and fall, glitches in between
    lvl = 1'b0;
    for (int t = 0; t < 4; t++) begin
      lvl = ~lvl;
      gpio_edge(lvl);
      gpio_hold(lvl, 4);
      repeat (3) begin
        g = 1 + ($unsigned($random(seed)) % (DEB_LEN - 1));
        gpio_hold(~lvl, g);
        gpio_hold(lvl, DEB_LEN + 4);
      end
    end
    $display("Simulation finished: PASS");
    $finish;
  end

  // replay plus generous room for the debounce phase
  initial begin : watchdog
    repeat (RST_CYC + NREC + 40 * DEB_LEN) @(posedge adc_clk);
    $display("watchdog expired, the run hung and did not reach the end");
    abort_run();
  end

endmodule : board_top_tb

// ==== verif/calib_patterns.mem ====
// flg adc0 adc1 | adc gain0 off0 gain1 off1 | dac gain0 off0 gain1 off1 | gen0 gen1 | xadc0 xadc1 xdac0 xdac1
// flg bit0 check, bits 2:1 loop select per channel, 16 bit hex words, offsets and samples in low 14 bits
0001 8000 0000 4000 0000 4000 0000 4000 0000 4000 0000 0000 1FFF 3FFF 1FFF 1FFF 0000
0001 FFFF 7FFC 4000 0000 4000 0000 4000 0000 4000 0000 2000 3FFF 2000 0000 3FFF 2000
0001 1234 A5A4 4000 0000 4000 0000 4000 0000 4000 0000 0123 2ABC 1B72 3696 1EDC 3543
0001 4003 C001 4000 0000 4000 0000 4000 0000 4000 0000 1000 0001 0FFF 2FFF 0FFF 1FFE
0000 0000 0000 4000 0000 4000 0000 4000 0000 4000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 4000 0000 4000 0000 4000 0000 4000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 4000 0000 4000 0000 4000 0000 4000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 4000 0000 4000 0000 4000 0000 4000 0000 0000 0000 0000 0000 0000 0000
0001 0000 0000 2000 1770 C000 3FCE 6000 000A 7FFF 3C18 1770 2000 1FFF 2000 0000 3FFF
0001 FFFF FFFF 2000 1770 C000 3FCE 6000 000A 7FFF 3C18 2000 1000 0770 1FCE 3FFF 03E8
0001 A5A4 1234 2000 1770 C000 3FCE 6000 000A 7FFF 3C18 3FFD 0003 12BB 245C 1FFA 23E2
0001 C001 4003 2000 1770 C000 3FCE 6000 000A 7FFF 3C18 0101 3F00 0F6F 2FCF 1E74 25E7
0000 0000 0000 2000 1770 C000 3FCE 6000 000A 7FFF 3C18 0000 0000 0000 0000 0000 0000
0000 0000 0000 2000 1770 C000 3FCE 6000 000A 7FFF 3C18 0000 0000 0000 0000 0000 0000
0000 0000 0000 2000 1770 C000 3FCE 6000 000A 7FFF 3C18 0000 0000 0000 0000 0000 0000
0000 0000 0000 2000 1770 C000 3FCE 6000 000A 7FFF 3C18 0000 0000 0000 0000 0000 0000
0003 7FFC 0000 2000 1770 C000 3FCE 6000 000A 7FFF 3C18 0000 2000 1775 2000 1FF5 3FFF
0003 7FFC FFFF 2000 1770 C000 3FCE 6000 000A 7FFF 3C18 1770 1000 1FFF 1FCE 0000 03E8
0003 7FFC 1234 2000 1770 C000 3FCE 6000 000A 7FFF 3C18 2000 0003 0770 245C 3FFF 23E2
0003 7FFC 4003 2000 1770 C000 3FCE 6000 000A 7FFF 3C18 3FFD 3F00 1772 2FCF 1FFA 25E7
0003 7FFC 7FFC 2000 1770 C000 3FCE 6000 000A 7FFF 3C18 3F9C 0000 172A 3FCE 208B 23E7
0003 7FFC 8000 2000 1770 C000 3FCE 6000 000A 7FFF 3C18 0007 1FFF 177A 3FCF 1FEB 0000

// ==== files.f ====
+incdir+include
source/board_pkg.sv
source/adc_capture.sv
source/calib_linear.sv
source/dac_format.sv
source/gpio_debounce.sv
source/board_top.sv
verif/board_top_tb.sv

// ==== Bender.yml ====
package:
  name: board_top

sources:
  - include_dirs:
      - include
    files:
      - source/board_pkg.sv
      - source/adc_capture.sv
      - source/calib_linear.sv
      - source/dac_format.sv
      - source/gpio_debounce.sv
      - source/board_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/board_top_tb.sv
